//--- Bender.yml
package:
  name: rhythm_rush

sources:
  - files:
      - hw/gamePkg.sv
      - hw/audioPkg.sv
      - hw/noteControl.sv
      - hw/spritePainter.sv
      - hw/laneTracker.sv
      - hw/keySequencer.sv
      - hw/toneMixer.sv
      - hw/rhythmRush.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/rhythmRushTb.sv

//--- files.f
+incdir+include
hw/gamePkg.sv
hw/audioPkg.sv
hw/noteControl.sv
hw/spritePainter.sv
hw/laneTracker.sv
hw/keySequencer.sv
hw/toneMixer.sv
hw/rhythmRush.sv
verif/rhythmRushTb.sv

//--- hw/audioPkg.sv
`default_nettype none

package audioPkg;

	// one signed stereo channel sample
	typedef logic signed [31:0] sampleT;

	// half-period counter of the square wave
	typedef logic [18:0] toneCountT;

	// square wave amplitude added to the sample
	localparam sampleT ToneAmp = 32'sd10000000;

	// key code lands in the top bits of the half period
	localparam int ToneShift = 15;

endpackage

`default_nettype wire

//--- hw/gamePkg.sv
`default_nettype none

package gamePkg;

	////////////////////////////////////////
	// coordinate and pixel types
	////////////////////////////////////////

	// screen column, 160 wide
	typedef logic [7:0] xCoordT;
	// screen row, 120 high
	typedef logic [6:0] yCoordT;
	// one bit per colour channel
	typedef logic [2:0] colourT;
	// lane index 0 to 2
	typedef logic [1:0] laneT;
	// wraps modulo 16
	typedef logic [3:0] scoreT;

	// key order tracker states
	typedef enum logic [2:0] {
		expectA,
		releaseA,
		expectB,
		releaseB,
		expectC,
		releaseC,
		finished
	} keySeqT;

	////////////////////////////////////////
	// geometry and colours
	////////////////////////////////////////

	// note block side in pixels
	localparam int NoteSize = 16;
	localparam int ScreenRows = 120;
	// bottom row, the note wraps past it
	localparam yCoordT LastRow = yCoordT'(ScreenRows - 1);

	// left edge of each lane
	localparam xCoordT LaneX0 = 8'd28;
	localparam xCoordT LaneX1 = 8'd68;
	localparam xCoordT LaneX2 = 8'd108;

	// first note position
	localparam xCoordT StartX = 8'd20;
	localparam yCoordT StartY = 7'd0;

	// pink note on black
	localparam colourT NoteColour = 3'b101;
	localparam colourT BackColour = 3'b000;

endpackage

`default_nettype wire

//--- hw/keySequencer.sv
`default_nettype none

module keySequencer
	import gamePkg::*;
(
	input logic Clock,
	input logic rstN,
	input logic [2:0] keys,
	output keySeqT seqState
);

	keySeqT nextState;

	////////////////////////////////////////
	// press then release, A, B, C in order
	////////////////////////////////////////

	always_comb
	begin
		nextState = seqState;
		case (seqState)
			expectA:
				if (keys[0])
					nextState = releaseA;
			releaseA:
				if (!keys[0])
					nextState = expectB;
			expectB:
				if (keys[1])
					nextState = releaseB;
			releaseB:
				if (!keys[1])
					nextState = expectC;
			expectC:
				if (keys[2])
					nextState = releaseC;
			releaseC:
				if (!keys[2])
					nextState = finished;
			// round done, start over
			finished:
				nextState = expectA;
			default:
				nextState = expectA;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
			seqState <= expectA;
		else
			seqState <= nextState;
	end

	// the eighth encoding is never reached
	assert property (@(posedge Clock) disable iff (!rstN)
		seqState inside {expectA, releaseA, expectB, releaseB,
			expectC, releaseC, finished});

endmodule

`default_nettype wire

//--- hw/laneTracker.sv
`default_nettype none

module laneTracker
	import gamePkg::*;
(
	input logic Clock,
	input logic rstN,
	input logic advance,
	input keySeqT seqState,
	output xCoordT noteX,
	output yCoordT noteY,
	output scoreT score
);

	laneT lane;
	xCoordT laneEdge;
	keySeqT landState;

	// left edge of the current lane
	always_comb
	begin
		case (lane)
			2'd0: laneEdge = LaneX0;
			2'd1: laneEdge = LaneX1;
			default: laneEdge = LaneX2;
		endcase
	end

	// sequencer state that wins a point in this lane
	always_comb
	begin
		case (lane)
			2'd0: landState = releaseA;
			2'd1: landState = releaseB;
			default: landState = releaseC;
		endcase
	end

	////////////////////////////////////////
	// position and score update
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			noteX <= StartX;
			noteY <= StartY;
			lane <= 2'd0;
			score <= '0;
		end
		else if (advance)
		begin
			if (noteY < LastRow)
			begin
				// fall one row, snap to the lane
				noteY <= noteY + 1'b1;
				noteX <= laneEdge;
			end
			else
			begin
				// landing, rotate to the next lane
				noteY <= '0;
				lane <= (lane == 2'd2) ? 2'd0 : lane + 1'b1;
				if (seqState == landState)
					score <= score + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/noteControl.sv
`default_nettype none

module noteControl
#(
	parameter int FrameDelay = 5500000
)
(
	input logic Clock,
	input logic rstN,
	input logic paintDone,
	output logic paintStart,
	output logic paintErase,
	output logic advance
);

	// wide enough to reach FrameDelay
	localparam int HoldW = $clog2(FrameDelay + 1);

	typedef enum logic [2:0] {
		sIdle,
		sDraw,
		sHold,
		sErase,
		sAdvance
	} stateT;

	stateT state;
	logic [HoldW-1:0] holdCount;

	////////////////////////////////////////
	// frame state machine
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= sIdle;
			holdCount <= '0;
			paintStart <= 1'b0;
		end
		else
		begin
			// start is a single cycle pulse
			paintStart <= 1'b0;
			case (state)
				sIdle:
				begin
					state <= sDraw;
					paintStart <= 1'b1;
				end
				sDraw:
					if (paintDone)
					begin
						state <= sHold;
						holdCount <= '0;
					end
				// note stays on screen, counter free of pixel stalls
				sHold:
					if (holdCount == HoldW'(FrameDelay - 1))
					begin
						state <= sErase;
						paintStart <= 1'b1;
					end
					else
						holdCount <= holdCount + 1'b1;
				sErase:
					if (paintDone)
						state <= sAdvance;
				// one cycle for the tracker to move the note
				sAdvance:
				begin
					state <= sDraw;
					paintStart <= 1'b1;
				end
				default:
					state <= sIdle;
			endcase
		end
	end

	// steady across the whole erase paint
	assign paintErase = (state == sErase);
	assign advance = (state == sAdvance);

	// painter only finishes a paint that was started
	assert property (@(posedge Clock) disable iff (!rstN)
		paintDone |-> (state == sDraw || state == sErase));

endmodule

`default_nettype wire

//--- hw/rhythmRush.sv
`default_nettype none

module rhythmRush
	import gamePkg::*, audioPkg::*;
#(
	parameter int FrameDelay = 5500000,
	parameter int PixelCredits = 4,
	parameter int SampleCredits = 2,
	parameter int ToneBase = 8000
)
(
	input logic Clock,
	input logic rstN,
	input logic [2:0] keys,

	// pixel stream toward the frame buffer
	output logic pixelValid,
	output xCoordT pixelX,
	output yCoordT pixelY,
	output colourT pixelColour,
	input logic pixelCredit,

	// game status
	output scoreT score,
	output keySeqT keyStage,

	// audio in, valid/accept
	input logic inValid,
	input sampleT inLeft,
	input sampleT inRight,
	output logic inAccept,

	// audio out, credit based
	output logic outValid,
	output sampleT outLeft,
	output sampleT outRight,
	input logic outCredit
);

	////////////////////////////////////////
	// control to datapath links
	////////////////////////////////////////

	logic paintStart;
	logic paintErase;
	logic paintDone;
	logic advance;
	xCoordT noteX;
	yCoordT noteY;

	// frame sequencing
	noteControl #(
		.FrameDelay(FrameDelay)
	) control0 (
		.Clock(Clock),
		.rstN(rstN),
		.paintDone(paintDone),
		.paintStart(paintStart),
		.paintErase(paintErase),
		.advance(advance)
	);

	// pixel generator for the note block
	spritePainter #(
		.PixelCredits(PixelCredits)
	) painter0 (
		.Clock(Clock),
		.rstN(rstN),
		.paintStart(paintStart),
		.paintErase(paintErase),
		.noteX(noteX),
		.noteY(noteY),
		.pixelCredit(pixelCredit),
		.paintDone(paintDone),
		.pixelValid(pixelValid),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour)
	);

	// position, lane and score
	laneTracker tracker0 (
		.Clock(Clock),
		.rstN(rstN),
		.advance(advance),
		.seqState(keyStage),
		.noteX(noteX),
		.noteY(noteY),
		.score(score)
	);

	// press and release order
	keySequencer sequencer0 (
		.Clock(Clock),
		.rstN(rstN),
		.keys(keys),
		.seqState(keyStage)
	);

	////////////////////////////////////////
	// audio path
	////////////////////////////////////////

	toneMixer #(
		.SampleCredits(SampleCredits),
		.ToneBase(ToneBase)
	) mixer0 (
		.Clock(Clock),
		.rstN(rstN),
		.keys(keys),
		.inValid(inValid),
		.inLeft(inLeft),
		.inRight(inRight),
		.outCredit(outCredit),
		.inAccept(inAccept),
		.outValid(outValid),
		.outLeft(outLeft),
		.outRight(outRight)
	);

endmodule

`default_nettype wire

//--- hw/spritePainter.sv
`default_nettype none

module spritePainter
	import gamePkg::*;
#(
	parameter int PixelCredits = 4
)
(
	input logic Clock,
	input logic rstN,
	input logic paintStart,
	input logic paintErase,
	input xCoordT noteX,
	input yCoordT noteY,
	input logic pixelCredit,
	output logic paintDone,
	output logic pixelValid,
	output xCoordT pixelX,
	output yCoordT pixelY,
	output colourT pixelColour
);

	localparam int SideW = $clog2(NoteSize);
	localparam int LastPixel = NoteSize * NoteSize - 1;
	localparam int CreditW = $clog2(PixelCredits + 1);

	logic busy;
	logic [2*SideW-1:0] pixIndex;
	logic [CreditW-1:0] credits;
	// one extra bit so rows past the screen do not wrap
	logic [7:0] rowSum;
	logic offScreen;
	logic step;

	////////////////////////////////////////
	// pixel address
	////////////////////////////////////////

	// row-major walk over the block
	assign rowSum = {1'b0, noteY} + 8'(pixIndex[2*SideW-1:SideW]);
	assign offScreen = rowSum > {1'b0, LastRow};

	// send only with a credit in hand
	assign pixelValid = busy && !offScreen && (credits != '0);
	// skipped pixels move on without a credit
	assign step = busy && (offScreen || credits != '0);

	assign pixelX = noteX + xCoordT'(pixIndex[SideW-1:0]);
	assign pixelY = yCoordT'(rowSum);
	assign pixelColour = paintErase ? BackColour : NoteColour;

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			pixIndex <= '0;
			paintDone <= 1'b0;
		end
		else
		begin
			paintDone <= 1'b0;
			if (paintStart && !busy)
			begin
				busy <= 1'b1;
				pixIndex <= '0;
			end
			else if (step)
			begin
				pixIndex <= pixIndex + 1'b1;
				// last pixel of the block ends the paint
				if (pixIndex == (2*SideW)'(LastPixel))
				begin
					busy <= 1'b0;
					paintDone <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// credit counter
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
			credits <= CreditW'(PixelCredits);
		else
			case ({pixelCredit, pixelValid})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
	end

	// count stays within the sink's capacity
	assert property (@(posedge Clock) disable iff (!rstN)
		credits <= CreditW'(PixelCredits));
	// sink never returns more than it was sent
	assert property (@(posedge Clock) disable iff (!rstN)
		pixelCredit |-> credits != CreditW'(PixelCredits));

endmodule

`default_nettype wire

//--- hw/toneMixer.sv
`default_nettype none

module toneMixer
	import audioPkg::*;
#(
	parameter int SampleCredits = 2,
	parameter int ToneBase = 8000
)
(
	input logic Clock,
	input logic rstN,
	input logic [2:0] keys,
	input logic inValid,
	input sampleT inLeft,
	input sampleT inRight,
	input logic outCredit,
	output logic inAccept,
	output logic outValid,
	output sampleT outLeft,
	output sampleT outRight
);

	localparam int CreditW = $clog2(SampleCredits + 1);

	toneCountT toneCount;
	toneCountT halfPeriod;
	logic phase;
	sampleT toneTerm;
	logic [CreditW-1:0] credits;

	////////////////////////////////////////
	// square wave
	////////////////////////////////////////

	// key code picks the pitch
	assign halfPeriod = (toneCountT'(keys) << ToneShift) + toneCountT'(ToneBase);

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			toneCount <= '0;
			phase <= 1'b0;
		end
		else if (toneCount == halfPeriod)
		begin
			toneCount <= '0;
			phase <= !phase;
		end
		else
			toneCount <= toneCount + 1'b1;
	end

	// silent with no key held
	always_comb
	begin
		if (keys == 3'b000)
			toneTerm = '0;
		else if (phase)
			toneTerm = ToneAmp;
		else
			toneTerm = -ToneAmp;
	end

	////////////////////////////////////////
	// sample mixing
	////////////////////////////////////////

	assign inAccept = inValid && (credits != '0);

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else
			outValid <= inAccept;
	end

	// mixed sample, loaded once per accept
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			outLeft <= '0;
			outRight <= '0;
		end
		else if (inAccept)
		begin
			outLeft <= inLeft + toneTerm;
			outRight <= inRight + toneTerm;
		end
	end

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
			credits <= CreditW'(SampleCredits);
		else
			case ({outCredit, inAccept})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
	end

	// sink holds at most SampleCredits samples
	assert property (@(posedge Clock) disable iff (!rstN)
		credits <= CreditW'(SampleCredits));

endmodule

`default_nettype wire

//--- include/rhythmModel.svh
`ifndef RHYTHM_MODEL_SVH
`define RHYTHM_MODEL_SVH

// cycle model of lanes, score, key order and tone
gamePkg::xCoordT expNoteX;
gamePkg::yCoordT expNoteY;
gamePkg::laneT expLane;
gamePkg::scoreT expScore;
gamePkg::keySeqT expSeq;
audioPkg::toneCountT expToneCount;
logic expPhase;
int expToneBase;

// state after rstN
function automatic void resetModel(int toneBase);
	expToneBase = toneBase;
	expNoteX = gamePkg::StartX;
	expNoteY = gamePkg::StartY;
	expLane = 2'd0;
	expScore = '0;
	expSeq = gamePkg::expectA;
	expToneCount = '0;
	expPhase = 1'b0;
endfunction

function automatic gamePkg::xCoordT laneEdgeOf(gamePkg::laneT lane);
	return (lane == 2'd0) ? gamePkg::LaneX0 :
		(lane == 2'd1) ? gamePkg::LaneX1 : gamePkg::LaneX2;
endfunction

// one advance pulse
function automatic void advanceNote();
	gamePkg::keySeqT landState;
	landState = (expLane == 2'd0) ? gamePkg::releaseA :
		(expLane == 2'd1) ? gamePkg::releaseB : gamePkg::releaseC;
	if (expNoteY < gamePkg::LastRow)
	begin
		expNoteY = expNoteY + 1'b1;
		expNoteX = laneEdgeOf(expLane);
	end
	else
	begin
		expNoteY = '0;
		if (expSeq == landState)
			expScore = expScore + 1'b1;
		expLane = (expLane == 2'd2) ? 2'd0 : expLane + 1'b1;
	end
endfunction

// one clock of the sequencer
function automatic void stepSequencer(logic [2:0] keys);
	case (expSeq)
		gamePkg::expectA:
			if (keys[0])
				expSeq = gamePkg::releaseA;
		gamePkg::releaseA:
			if (!keys[0])
				expSeq = gamePkg::expectB;
		gamePkg::expectB:
			if (keys[1])
				expSeq = gamePkg::releaseB;
		gamePkg::releaseB:
			if (!keys[1])
				expSeq = gamePkg::expectC;
		gamePkg::expectC:
			if (keys[2])
				expSeq = gamePkg::releaseC;
		gamePkg::releaseC:
			if (!keys[2])
				expSeq = gamePkg::finished;
		default:
			expSeq = gamePkg::expectA;
	endcase
endfunction

// tone added to a sample accepted this cycle
function automatic audioPkg::sampleT toneTermFor(logic [2:0] keys);
	audioPkg::sampleT term;
	if (keys == 3'b000)
		term = '0;
	else if (expPhase)
		term = audioPkg::ToneAmp;
	else
		term = -audioPkg::ToneAmp;
	return term;
endfunction

// one clock of the tone counter
function automatic void stepTone(logic [2:0] keys);
	audioPkg::toneCountT halfPeriod;
	halfPeriod = (audioPkg::toneCountT'(keys) << audioPkg::ToneShift)
		+ audioPkg::toneCountT'(expToneBase);
	if (expToneCount == halfPeriod)
	begin
		expToneCount = '0;
		expPhase = !expPhase;
	end
	else
		expToneCount = expToneCount + 1'b1;
endfunction

`endif

//--- verif/rhythmRushTb.sv
`default_nettype none

module rhythmRushTb
	import gamePkg::*, audioPkg::*;
();

	////////////////////////////////////////
	// run length and limits
	////////////////////////////////////////

	localparam int FrameDelay = 40;
	localparam int ToneBase = 20;
	localparam int PixelCredits = 4;
	localparam int SampleCredits = 2;
	localparam logic [31:0] Seed = 32'he424ff7a;
	// three bottom landings and a bit more
	localparam int FrameTarget = 370;
	// longest wait of the sinks for one credit return
	localparam int MaxCreditGap = 8;
	localparam int PaintWorst = NoteSize * NoteSize * MaxCreditGap + 8;
	localparam int FrameWorst = 2 * PaintWorst + FrameDelay + 8;
	localparam int TimeoutCycles = 400 * FrameWorst;

	`include "rhythmModel.svh"

	logic Clock;
	logic rstN;
	logic [2:0] keys;
	logic pixelValid;
	xCoordT pixelX;
	yCoordT pixelY;
	colourT pixelColour;
	logic pixelCredit;
	scoreT score;
	keySeqT keyStage;
	logic inValid;
	sampleT inLeft;
	sampleT inRight;
	logic inAccept;
	logic outValid;
	sampleT outLeft;
	sampleT outRight;
	logic outCredit;

	logic [31:0] seed;
	logic [31:0] stim;

	// bookkeeping, cycle counts after reset release
	int cycle = 0;
	int keyTimer = 0;
	int pixOut = 0;
	int smpOut = 0;
	int pixGap = 0;
	int smpGap = 0;
	int mixCredits = SampleCredits;
	int pIdx = 0;
	bit paintIsErase = 1'b0;
	int paintEnd = 0;
	int eraseStart = 0;
	int advanceAt = -1;
	int advanceCount = 0;
	int wrapCount = 0;
	int sampleCount = 0;
	bit pendValid = 1'b0;
	bit expAccept;
	sampleT pendLeft;
	sampleT pendRight;

	rhythmRush #(
		.FrameDelay(FrameDelay),
		.PixelCredits(PixelCredits),
		.SampleCredits(SampleCredits),
		.ToneBase(ToneBase)
	) dut0 (
		.Clock(Clock),
		.rstN(rstN),
		.keys(keys),
		.pixelValid(pixelValid),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.pixelCredit(pixelCredit),
		.score(score),
		.keyStage(keyStage),
		.inValid(inValid),
		.inLeft(inLeft),
		.inRight(inRight),
		.inAccept(inAccept),
		.outValid(outValid),
		.outLeft(outLeft),
		.outRight(outRight),
		.outCredit(outCredit)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// plain LCG, numerical recipes constants
	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic haltOnError();
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic reportProblem(string what);
		$display("%s", what);
		haltOnError();
	endtask

	task automatic columnCheck(string name, xCoordT expected, xCoordT actual);
		if (actual !== expected)
		begin
			$display("FAIL time %0t %s expected %0d got %0d", $time, name, expected, actual);
			haltOnError();
		end
	endtask

	task automatic rowCheck(string name, yCoordT expected, yCoordT actual);
		if (actual !== expected)
		begin
			$display("FAIL time %0t %s expected %0d got %0d", $time, name, expected, actual);
			haltOnError();
		end
	endtask

	task automatic colourCheck(string name, colourT expected, colourT actual);
		if (actual !== expected)
		begin
			$display("FAIL time %0t %s expected %b got %b", $time, name, expected, actual);
			haltOnError();
		end
	endtask

	task automatic scoreCheck(string name, scoreT expected, scoreT actual);
		if (actual !== expected)
		begin
			$display("FAIL time %0t %s expected %0d got %0d", $time, name, expected, actual);
			haltOnError();
		end
	endtask

	task automatic stageCheck(string name, keySeqT expected, keySeqT actual);
		if (actual !== expected)
		begin
			$display("FAIL time %0t %s expected %s got %s (%0d)", $time, name,
				expected.name(), actual.name(), actual);
			haltOnError();
		end
	endtask

	task automatic sampleCheck(string name, sampleT expected, sampleT actual);
		if (actual !== expected)
		begin
			$display("FAIL time %0t %s expected %0d got %0d", $time, name, expected, actual);
			haltOnError();
		end
	endtask

	task automatic flagCheck(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("FAIL time %0t %s expected %b got %b", $time, name, expected, actual);
			haltOnError();
		end
	endtask

	////////////////////////////////////////
	// clock, reset and run control
	////////////////////////////////////////

	initial
	begin
		Clock = 1'b0;
		forever
			#5 Clock = ~Clock;
	end

	initial
	begin
		resetModel(ToneBase);
		seed = Seed;
		rstN = 1'b0;
		keys = 3'b000;
		inValid = 1'b0;
		inLeft = '0;
		inRight = '0;
		pixelCredit = 1'b0;
		outCredit = 1'b0;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		rstN = 1'b1;
		while (advanceCount < FrameTarget)
			@(negedge Clock);
		// must have seen every lane land and some audio
		if (wrapCount < 3 || sampleCount == 0)
			reportProblem("run ended without three landings or without any audio sample");
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus and sinks, falling edge
	////////////////////////////////////////

	always @(negedge Clock)
	begin
		stim = nextRandom();
		// keys roughly every 50 cycles
		if (keyTimer == 0)
		begin
			keys = stim[31:29];
			keyTimer = 40 + int'(stim[7:0]) % 21;
		end
		else
			keyTimer--;
		inValid = stim[20];
		inLeft = sampleT'(nextRandom());
		inRight = sampleT'(nextRandom());
		// pixel sink, one credit back per gap
		pixelCredit = 1'b0;
		if (pixOut > 0)
		begin
			if (pixGap == 0)
			begin
				pixelCredit = 1'b1;
				pixOut--;
				pixGap = int'(stim[12:10]);
			end
			else
				pixGap--;
		end
		// sample sink, same scheme
		outCredit = 1'b0;
		if (smpOut > 0)
		begin
			if (smpGap == 0)
			begin
				outCredit = 1'b1;
				smpOut--;
				smpGap = int'(stim[15:13]);
			end
			else
				smpGap--;
		end
	end

	////////////////////////////////////////
	// response checks, rising edge
	////////////////////////////////////////

	// values read here are the ones the DUT samples on this edge
	always @(posedge Clock)
	begin
		if (rstN)
		begin
			cycle++;
			if (cycle > TimeoutCycles)
				reportProblem("timeout, the note stopped advancing");
			stageCheck("keyStage", expSeq, keyStage);
			scoreCheck("score", expScore, score);

			// output sample one cycle after its accept
			flagCheck("outValid", pendValid, outValid);
			if (pendValid)
			begin
				sampleCheck("outLeft", pendLeft, outLeft);
				sampleCheck("outRight", pendRight, outRight);
				sampleCount++;
				smpOut++;
				if (smpOut > SampleCredits)
					reportProblem("audio sink holds more samples than SampleCredits");
			end
			expAccept = inValid && (mixCredits > 0);
			flagCheck("inAccept", expAccept, inAccept);
			pendValid = expAccept;
			pendLeft = inLeft + toneTermFor(keys);
			pendRight = inRight + toneTermFor(keys);
			mixCredits = mixCredits + int'(outCredit) - int'(expAccept);

			// pixel stream against the model block
			if (pixelValid)
			begin
				if (advanceAt >= 0)
					reportProblem("pixel sent before the note advanced");
				// credits are back long before the hold ends
				if (pIdx == 0 && paintIsErase && cycle != eraseStart)
					reportProblem("erase paint did not begin right after the frame hold");
				columnCheck("pixelX", expNoteX + xCoordT'(pIdx % NoteSize), pixelX);
				rowCheck("pixelY", expNoteY + yCoordT'(pIdx / NoteSize), pixelY);
				colourCheck("pixelColour", paintIsErase ? BackColour : NoteColour,
					pixelColour);
				pIdx++;
				pixOut++;
				if (pixOut > PixelCredits)
					reportProblem("pixel sink holds more pixels than PixelCredits");
				// block done, trailing off-screen pixels cost a cycle each
				if (pIdx == NoteSize * NoteSize
					|| int'(expNoteY) + pIdx / NoteSize > int'(LastRow))
				begin
					paintEnd = cycle + NoteSize * NoteSize - pIdx;
					if (paintIsErase)
						advanceAt = paintEnd + 2;
					else
						eraseStart = paintEnd + FrameDelay + 3;
					paintIsErase = !paintIsErase;
					pIdx = 0;
				end
			end

			// advance pulse, uses the sequencer state before this edge
			if (cycle == advanceAt)
			begin
				if (expNoteY == LastRow)
					wrapCount++;
				advanceNote();
				advanceCount++;
				advanceAt = -1;
			end

			stepSequencer(keys);
			stepTone(keys);
		end
	end

endmodule

`default_nettype wire
